//--- source/si_req_pkg.sv
`default_nettype none

package si_req_pkg;

    // command byte positions, bytes 2 to 5 are reserved and skipped
    localparam int CMD_LEN      = 17;
    localparam int CMD_SFP_POS  = 6;
    localparam int CMD_IP_POS   = 7;   // 4 bytes, msb first
    localparam int CMD_PORT_POS = 11;  // 2 bytes
    localparam int CMD_PID_POS  = 13;  // 2 bytes, top 3 bits dropped
    localparam int CMD_TID_POS  = 15;
    localparam int CMD_SEC_POS  = 16;

    typedef struct packed {
        logic [15:0] tag;   // echoed in the reply head
        logic [7:0]  sfp;
        logic [31:0] ip;
        logic [15:0] port;
        logic [12:0] pid;
        logic [7:0]  tid;   // table id
        logic [7:0]  sec;   // section index
    } si_req_t;

    localparam logic [7:0] REPLY_HEAD0 = 8'h04;
    localparam logic [7:0] REPLY_HEAD1 = 8'h01;

    typedef enum logic [1:0] {
        RPL_IDLE,
        RPL_HEAD,
        RPL_DATA
    } reply_state_e;

endpackage

`default_nettype wire

//--- source/ts_pkg.sv
`default_nettype none

package ts_pkg;

    localparam int         TS_PKT_BYTES   = 188;
    localparam logic [7:0] TS_SYNC        = 8'h47;
    localparam int         TS_HDR_WORDS   = 3;    // sfp, ip, port
    localparam int         TS_FIFO_PTR_W  = 6;
    localparam int         TS_FIFO_WORDS  = 1 << TS_FIFO_PTR_W;
    localparam int         SEC_ADDR_W     = 12;   // 4096 byte section buffer
    localparam int         SEC_NUM_POS    = 6;    // section_number offset

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       pkt_first;  // byte 0 of a 188 byte packet
    } ts_byte_t;

    typedef enum logic [3:0] {
        IDLE,
        PID_HI,
        PID_LO,
        CC_CHECK,
        ADAPT_CTRL,
        ADAPT_LEN,
        ADAPT_SKIP,
        PTR_LEN,
        PTR_SKIP,
        TID_CHECK,
        WRITE,
        WAIT_PKT,
        DONE
    } cap_state_e;

endpackage

`default_nettype wire

//--- source/si_cmd_parser.sv
`timescale 1ns/100ps
`default_nettype none

module si_cmd_parser
    import si_req_pkg::*;
(
    input  wire logic       i_clk,
    input  wire logic       i_reset,
    input  wire logic [7:0] i_con,
    input  wire logic       i_con_en,
    output si_req_t         o_req,
    output logic            o_arm
);

    logic [4:0] cnt;  // byte position inside the command

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            cnt   <= '0;
            o_arm <= 1'b0;
        end
        else
        begin
            cnt   <= i_con_en ? cnt + 5'd1 : 5'd0;
            o_arm <= i_con_en && (cnt == 5'(CMD_LEN - 1));
        end
    end

    // request fields hold until the next command
    always_ff @(posedge i_clk)
    begin
        if (i_con_en)
        begin
            case (cnt)
                0:                o_req.tag[15:8]  <= i_con;
                1:                o_req.tag[7:0]   <= i_con;
                CMD_SFP_POS:      o_req.sfp        <= i_con;
                CMD_IP_POS:       o_req.ip[31:24]  <= i_con;
                CMD_IP_POS + 1:   o_req.ip[23:16]  <= i_con;
                CMD_IP_POS + 2:   o_req.ip[15:8]   <= i_con;
                CMD_IP_POS + 3:   o_req.ip[7:0]    <= i_con;
                CMD_PORT_POS:     o_req.port[15:8] <= i_con;
                CMD_PORT_POS + 1: o_req.port[7:0]  <= i_con;
                CMD_PID_POS:      o_req.pid[12:8]  <= i_con[4:0];
                CMD_PID_POS + 1:  o_req.pid[7:0]   <= i_con;
                CMD_TID_POS:      o_req.tid        <= i_con;
                CMD_SEC_POS:      o_req.sec        <= i_con;
                default:          ;  // reserved bytes
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/ts_stream_filter.sv
`timescale 1ns/100ps
`default_nettype none

module ts_stream_filter
    import si_req_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    input  wire logic [32:0] i_ts,
    input  wire logic        i_ts_en,
    input  wire si_req_t     i_req,
    output logic [31:0]      o_word,
    output logic             o_wr
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_IP,
        F_PORT,
        F_PASS
    } filt_state_e;

    filt_state_e state;
    logic        en_r;  // for the burst start edge

    always_ff @(posedge i_clk)
    begin
        o_word <= i_ts[31:0];
        if (i_reset)
        begin
            state <= F_IDLE;
            en_r  <= 1'b0;
            o_wr  <= 1'b0;
        end
        else
        begin
            en_r <= i_ts_en;
            o_wr <= (state == F_PASS) && i_ts_en;
            case (state)
                F_IDLE:
                    if (i_ts_en && !en_r && i_ts[32] && i_ts[7:0] == i_req.sfp)
                        state <= F_IP;
                F_IP:   state <= (i_ts[31:0] == i_req.ip) ? F_PORT : F_IDLE;
                F_PORT: state <= (i_ts[15:0] == i_req.port) ? F_PASS : F_IDLE;
                default:
                    if (!i_ts_en)
                        state <= F_IDLE;  // burst over
            endcase
        end
    end

endmodule

`default_nettype wire

//--- source/ts_word_fifo.sv
`timescale 1ns/100ps
`default_nettype none

module ts_word_fifo
    import ts_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    input  wire logic [31:0] i_word,
    input  wire logic        i_wr,
    output ts_byte_t         o_byte
);

    logic [31:0]              mem [TS_FIFO_WORDS];
    logic [TS_FIFO_PTR_W-1:0] wr_ptr;
    logic [TS_FIFO_PTR_W-1:0] rd_ptr;
    logic [TS_FIFO_PTR_W:0]   fill;      // words held
    logic [1:0]               byte_sel;  // 0 is the msb byte
    logic [7:0]               pkt_cnt;
    logic                     rd_en;
    logic                     pop;
    logic                     full;

    assign rd_en = (fill != '0);
    assign pop   = rd_en && (byte_sel == 2'd3);
    assign full  = (fill == (TS_FIFO_PTR_W + 1)'(TS_FIFO_WORDS));

    always_ff @(posedge i_clk)
    begin
        if (i_wr)
            mem[wr_ptr] <= i_word;
    end

    always_ff @(posedge i_clk)
    begin
        o_byte.data <= mem[rd_ptr][8 * (3 - byte_sel) +: 8];
        if (i_reset)
        begin
            wr_ptr           <= '0;
            rd_ptr           <= '0;
            fill             <= '0;
            byte_sel         <= '0;
            pkt_cnt          <= '0;
            o_byte.valid     <= 1'b0;
            o_byte.pkt_first <= 1'b0;
        end
        else
        begin
            if (i_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            fill <= fill + (TS_FIFO_PTR_W + 1)'(i_wr) - (TS_FIFO_PTR_W + 1)'(pop);
            if (rd_en)
                byte_sel <= byte_sel + 2'd1;

            // packet position, restarts whenever the fifo runs dry
            if (!rd_en || pkt_cnt == 8'(TS_PKT_BYTES - 1))
                pkt_cnt <= '0;
            else
                pkt_cnt <= pkt_cnt + 8'd1;

            o_byte.valid     <= rd_en;
            o_byte.pkt_first <= rd_en && (pkt_cnt == '0);
        end
    end

    a_no_overflow: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wr |-> !full);

endmodule

`default_nettype wire

//--- source/si_section_capture.sv
`timescale 1ns/100ps
`default_nettype none

module si_section_capture
    import si_req_pkg::*;
    import ts_pkg::*;
(
    input  wire logic              i_clk,
    input  wire logic              i_reset,
    input  wire ts_byte_t          i_byte,
    input  wire si_req_t           i_req,
    input  wire logic              i_arm,
    output logic                   o_ram_we,
    output logic [SEC_ADDR_W-1:0]  o_ram_addr,
    output logic [7:0]             o_ram_data,
    output logic [SEC_ADDR_W-1:0]  o_sec_len,
    output logic                   o_done
);

    cap_state_e              state;
    logic                    armed;
    logic                    in_sec;     // section partly written
    logic                    pusi;       // payload unit start of this packet
    logic [3:0]              cc;         // last continuity count
    logic [7:0]              skip_cnt;
    logic [SEC_ADDR_W-1:0]   len_field;
    logic [SEC_ADDR_W-1:0]   wr_cnt;
    logic                    new_pkt;

    assign new_pkt   = i_byte.valid && i_byte.pkt_first;
    assign o_sec_len = len_field + SEC_ADDR_W'(3);  // length field excludes 3 bytes

    ////////////////////////////////////////////////////////////////////////////
    // packet walk

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state    <= IDLE;
            armed    <= 1'b0;
            in_sec   <= 1'b0;
            o_ram_we <= 1'b0;
            o_done   <= 1'b0;
        end
        else
        begin
            o_ram_we <= 1'b0;
            o_done   <= 1'b0;
            if (i_arm)
            begin
                state  <= IDLE;
                armed  <= 1'b1;
                in_sec <= 1'b0;
            end
            else if (state == DONE)
            begin
                state  <= IDLE;
                armed  <= 1'b0;  // one reply per command
                in_sec <= 1'b0;
                o_done <= 1'b1;
            end
            else if (new_pkt)
            begin
                if (armed && i_byte.data == TS_SYNC)
                    state <= PID_HI;
                else
                    state <= in_sec ? WAIT_PKT : IDLE;
            end
            else if (i_byte.valid)
            begin
                case (state)
                    PID_HI:
                    begin
                        pusi <= i_byte.data[6];
                        if (i_byte.data[4:0] == i_req.pid[12:8])
                            state <= PID_LO;
                        else
                            state <= in_sec ? WAIT_PKT : IDLE;
                    end
                    PID_LO:
                    begin
                        if (i_byte.data != i_req.pid[7:0])
                            state <= in_sec ? WAIT_PKT : IDLE;
                        else if (pusi)
                        begin
                            state  <= ADAPT_CTRL;  // fresh section start
                            in_sec <= 1'b0;
                        end
                        else
                            state <= in_sec ? CC_CHECK : IDLE;
                    end
                    CC_CHECK:
                    begin
                        cc <= i_byte.data[3:0];
                        if (i_byte.data[3:0] == cc + 4'd1)
                            state <= WRITE;
                        else
                        begin
                            state  <= IDLE;  // lost packet, wait for next start
                            in_sec <= 1'b0;
                        end
                    end
                    ADAPT_CTRL:
                    begin
                        cc <= i_byte.data[3:0];
                        case (i_byte.data[5:4])
                            2'b01:   state <= PTR_LEN;
                            2'b11:   state <= ADAPT_LEN;
                            default: state <= IDLE;  // no payload
                        endcase
                    end
                    ADAPT_LEN:
                    begin
                        skip_cnt <= i_byte.data;
                        state    <= (i_byte.data == '0) ? PTR_LEN : ADAPT_SKIP;
                    end
                    ADAPT_SKIP:
                    begin
                        skip_cnt <= skip_cnt - 8'd1;
                        if (skip_cnt == 8'd1)
                            state <= PTR_LEN;
                    end
                    PTR_LEN:
                    begin
                        skip_cnt <= i_byte.data;
                        state    <= (i_byte.data == '0) ? TID_CHECK : PTR_SKIP;
                    end
                    PTR_SKIP:
                    begin
                        skip_cnt <= skip_cnt - 8'd1;
                        if (skip_cnt == 8'd1)
                            state <= TID_CHECK;
                    end
                    TID_CHECK:
                    begin
                        if (i_byte.data == i_req.tid)
                        begin
                            o_ram_we   <= 1'b1;
                            o_ram_addr <= '0;
                            o_ram_data <= i_byte.data;
                            wr_cnt     <= SEC_ADDR_W'(1);
                            in_sec     <= 1'b1;
                            state      <= WRITE;
                        end
                        else
                            state <= IDLE;
                    end
                    WRITE:
                    begin
                        if (wr_cnt == SEC_NUM_POS && i_byte.data != i_req.sec)
                        begin
                            state  <= IDLE;  // other section of the table
                            in_sec <= 1'b0;
                        end
                        else
                        begin
                            o_ram_we   <= 1'b1;
                            o_ram_addr <= wr_cnt;
                            o_ram_data <= i_byte.data;
                            wr_cnt     <= wr_cnt + SEC_ADDR_W'(1);
                            if (wr_cnt == SEC_ADDR_W'(1))
                                len_field[11:8] <= i_byte.data[3:0];
                            if (wr_cnt == SEC_ADDR_W'(2))
                                len_field[7:0] <= i_byte.data;
                            if (wr_cnt > SEC_ADDR_W'(2) && wr_cnt + SEC_ADDR_W'(1) == o_sec_len)
                                state <= DONE;
                        end
                    end
                    default: ;  // IDLE and WAIT_PKT leave on a packet start
                endcase
            end
        end
    end

    // the write count never wraps past the end of the section RAM
    a_addr_in_ram: assert property (@(posedge i_clk) disable iff (i_reset)
        state == WRITE |-> wr_cnt != '0);

endmodule

`default_nettype wire

//--- source/si_section_ram.sv
`timescale 1ns/100ps
`default_nettype none

module si_section_ram
    import ts_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_we,
    input  wire logic [SEC_ADDR_W-1:0] i_waddr,
    input  wire logic [7:0]            i_wdata,
    input  wire logic [SEC_ADDR_W-1:0] i_raddr,
    output logic [7:0]                 o_rdata
);

    logic [7:0] mem [1 << SEC_ADDR_W];

    always_ff @(posedge i_clk)
    begin
        if (i_we)
            mem[i_waddr] <= i_wdata;
        o_rdata <= mem[i_raddr];  // one cycle read latency
    end

endmodule

`default_nettype wire

//--- source/si_reply_sender.sv
`timescale 1ns/100ps
`default_nettype none

module si_reply_sender
    import si_req_pkg::*;
    import ts_pkg::*;
(
    input  wire logic                  i_clk,
    input  wire logic                  i_reset,
    input  wire logic                  i_done,
    input  wire logic [SEC_ADDR_W-1:0] i_sec_len,
    input  wire logic [15:0]           i_tag,
    input  wire logic [7:0]            i_rdata,
    output logic [SEC_ADDR_W-1:0]      o_raddr,
    output logic [7:0]                 o_si,
    output logic                       o_si_en
);

    reply_state_e          state;
    logic [1:0]            head_cnt;
    logic [SEC_ADDR_W-1:0] len;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            state   <= RPL_IDLE;
            o_si_en <= 1'b0;
        end
        else
        begin
            o_si_en <= (state != RPL_IDLE) || i_done;
            case (state)
                RPL_IDLE:
                    if (i_done)
                        state <= RPL_HEAD;
                RPL_HEAD:
                    if (head_cnt == 2'd3)
                        state <= RPL_DATA;
                default:
                    if (o_raddr == len)
                        state <= RPL_IDLE;  // last byte goes out now
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // reply bytes, address 0 is prefetched during the last head byte

    always_ff @(posedge i_clk)
    begin
        case (state)
            RPL_IDLE:
            begin
                o_si     <= REPLY_HEAD0;
                head_cnt <= 2'd1;
                o_raddr  <= '0;
                if (i_done)
                    len <= i_sec_len;
            end
            RPL_HEAD:
            begin
                head_cnt <= head_cnt + 2'd1;
                case (head_cnt)
                    2'd1:    o_si <= REPLY_HEAD1;
                    2'd2:    o_si <= i_tag[15:8];
                    default: o_si <= i_tag[7:0];
                endcase
                if (head_cnt == 2'd3)
                    o_raddr <= o_raddr + SEC_ADDR_W'(1);
            end
            default:
            begin
                o_si    <= i_rdata;
                o_raddr <= o_raddr + SEC_ADDR_W'(1);
            end
        endcase
    end

    // capture stays disarmed until the reply is out
    a_done_idle: assert property (@(posedge i_clk) disable iff (i_reset)
        i_done |-> state == RPL_IDLE);

endmodule

`default_nettype wire

//--- source/si_grabber_top.sv
`timescale 1ns/100ps
`default_nettype none

module si_grabber_top
    import si_req_pkg::*;
    import ts_pkg::*;
(
    input  wire logic        i_clk,
    input  wire logic        i_reset,
    input  wire logic [32:0] i_ts,
    input  wire logic        i_ts_en,
    input  wire logic [7:0]  i_con,
    input  wire logic        i_con_en,
    output logic [7:0]       o_si,
    output logic             o_si_en
);

    si_req_t               req;
    logic                  arm;
    logic [31:0]           word;
    logic                  wr;
    ts_byte_t              ts_byte;
    logic                  ram_we;
    logic [SEC_ADDR_W-1:0] ram_waddr;
    logic [7:0]            ram_wdata;
    logic [SEC_ADDR_W-1:0] sec_len;
    logic                  done;
    logic [SEC_ADDR_W-1:0] ram_raddr;
    logic [7:0]            ram_rdata;

    si_cmd_parser u_parser (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_con    (i_con),
        .i_con_en (i_con_en),
        .o_req    (req),
        .o_arm    (arm)
    );

    ts_stream_filter u_filter (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_ts     (i_ts),
        .i_ts_en  (i_ts_en),
        .i_req    (req),
        .o_word   (word),
        .o_wr     (wr)
    );

    ts_word_fifo u_fifo (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_word   (word),
        .i_wr     (wr),
        .o_byte   (ts_byte)
    );

    si_section_capture u_capture (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_byte     (ts_byte),
        .i_req      (req),
        .i_arm      (arm),
        .o_ram_we   (ram_we),
        .o_ram_addr (ram_waddr),
        .o_ram_data (ram_wdata),
        .o_sec_len  (sec_len),
        .o_done     (done)
    );

    si_section_ram u_ram (
        .i_clk    (i_clk),
        .i_we     (ram_we),
        .i_waddr  (ram_waddr),
        .i_wdata  (ram_wdata),
        .i_raddr  (ram_raddr),
        .o_rdata  (ram_rdata)
    );

    si_reply_sender u_sender (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_done    (done),
        .i_sec_len (sec_len),
        .i_tag     (req.tag),
        .i_rdata   (ram_rdata),
        .o_raddr   (ram_raddr),
        .o_si      (o_si),
        .o_si_en   (o_si_en)
    );

endmodule

`default_nettype wire

//--- tb/tb_si_grabber.sv
`timescale 1ns/100ps
`default_nettype none

module tb_si_grabber;

    localparam int CLK_HALF    = 10;
    localparam int DRIVE_DLY   = 2;     // after the rising edge
    localparam int RESET_CYC   = 10;
    localparam int BURST_WORDS = 50;
    localparam int PKT_BYTES   = 188;
    localparam int BURST_GAP   = 240;   // idle cycles while the fifo drains
    localparam int REPLY_TMO   = 3000;
    localparam int SEC_NUM_OFS = 6;     // section_number inside a section
    localparam int END_QUIET   = 300;

    logic        i_clk;
    logic        i_reset;
    logic [32:0] i_ts;
    logic        i_ts_en;
    logic [7:0]  i_con;
    logic        i_con_en;
    logic [7:0]  o_si;
    logic        o_si_en;

    logic [7:0]  sec_mem [4096];   // section the stimulus currently sends
    int          sec_bytes;
    logic [7:0]  rx_bytes [$];
    int          rx_runs [$];      // length of each finished enable run
    int          run_len;
    int          fd;
    bit          abort;
    int          checks;
    int          value_errs;
    int          other_errs;

    si_grabber_top uut (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_ts     (i_ts),
        .i_ts_en  (i_ts_en),
        .i_con    (i_con),
        .i_con_en (i_con_en),
        .o_si     (o_si),
        .o_si_en  (o_si_en)
    );

    initial
        i_clk = 1'b0;

    always #CLK_HALF i_clk = ~i_clk;

    // every enable run becomes one entry of rx_runs
    always @(negedge i_clk)
    begin
        if (o_si_en)
        begin
            rx_bytes.push_back(o_si);
            run_len++;
        end
        else if (run_len != 0)
        begin
            rx_runs.push_back(run_len);
            run_len = 0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus file reading

    function automatic bit is_blank(input int ch);
        return ch == 32 || ch == 9 || ch == 10 || ch == 13;
    endfunction

    // next tag letter after blanks and # comment lines or -1 at end of file
    task automatic next_tag(output int ch);
        ch = $fgetc(fd);
        while (is_blank(ch) || ch == 35)
        begin
            if (ch == 35)
            begin
                while (ch != 10 && ch != -1)
                    ch = $fgetc(fd);
            end
            ch = $fgetc(fd);
        end
    endtask

    task automatic bad_line(input string what);
        $display("stimulus file: %s line could not be read", what);
        other_errs++;
        abort = 1'b1;
    endtask

    // section header fields over a pattern of the whole address
    task automatic build_section();
        logic [7:0]  tid;
        logic [7:0]  sec;
        logic [11:0] len_field;
        logic [7:0]  seed;
        logic [11:0] k;
        int          n_rd;
        int          i;
        n_rd = $fscanf(fd, "%h %h %h %h", tid, sec, len_field, seed);
        if (n_rd != 4)
            bad_line("S");
        for (i = 0; i < 4096; i++)
        begin
            k          = 12'(i);
            sec_mem[i] = k[7:0] + 8'h3d * {4'h0, k[11:8]} + seed;
        end
        sec_mem[0]           = tid;
        sec_mem[1]           = {4'hb, len_field[11:8]};
        sec_mem[2]           = len_field[7:0];
        sec_mem[SEC_NUM_OFS] = sec;
        sec_bytes            = int'(len_field) + 3;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // drivers

    task automatic send_command();
        logic [7:0] b;
        int         n_rd;
        int         i;
        for (i = 0; i < 17; i++)
        begin
            n_rd = $fscanf(fd, "%h", b);
            if (n_rd != 1)
                bad_line("C");
            @(posedge i_clk);
            #DRIVE_DLY;
            i_con    = b;
            i_con_en = 1'b1;
        end
        @(posedge i_clk);
        #DRIVE_DLY;
        i_con    = '0;
        i_con_en = 1'b0;
    endtask

    task automatic drive_word(input logic [32:0] w);
        @(posedge i_clk);
        #DRIVE_DLY;
        i_ts    = w;
        i_ts_en = 1'b1;
    endtask

    // one burst of three header words and one 188 byte packet
    task automatic send_burst();
        logic [7:0]  sfp;
        logic [31:0] ip;
        logic [15:0] port;
        logic [12:0] pid;
        logic        pusi;
        logic [3:0]  cc;
        logic [7:0]  alen;
        logic [7:0]  ptr;
        int          offset;
        logic [7:0]  pkt [PKT_BYTES];
        int          pos;
        int          src;
        int          n_rd;
        int          i;
        n_rd = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                       sfp, ip, port, pid, pusi, cc, alen, ptr, offset);
        if (n_rd != 9)
            bad_line("P");
        pkt[0] = 8'h47;
        pkt[1] = {1'b0, pusi, 1'b0, pid[12:8]};
        pkt[2] = pid[7:0];
        pkt[3] = {2'b00, (pusi && alen != 8'h00) ? 2'b11 : 2'b01, cc};
        pos    = 4;
        if (pusi)
        begin
            if (alen != 8'h00)
            begin
                pkt[pos] = alen;
                pos++;
                for (i = 0; i < int'(alen); i++)
                begin
                    pkt[pos] = 8'h00;
                    pos++;
                end
            end
            pkt[pos] = ptr;    // pointer field
            pos++;
            for (i = 0; i < int'(ptr); i++)
            begin
                pkt[pos] = 8'haa;  // tail of an earlier section
                pos++;
            end
        end
        src = offset;
        for (i = pos; i < PKT_BYTES; i++)
        begin
            if (src < sec_bytes)
                pkt[i] = sec_mem[src];
            else
                pkt[i] = 8'hff;  // stuffing
            src++;
        end

        drive_word({1'b1, 24'h0, sfp});
        drive_word({1'b0, ip});
        drive_word({1'b0, 16'h0, port});
        for (i = 0; i < BURST_WORDS - 3; i++)
            drive_word({1'b0, pkt[4 * i], pkt[4 * i + 1], pkt[4 * i + 2], pkt[4 * i + 3]});
        @(posedge i_clk);
        #DRIVE_DLY;
        i_ts    = '0;
        i_ts_en = 1'b0;
        repeat (BURST_GAP) @(posedge i_clk);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // checkers

    task automatic check_reply();
        logic [15:0] tag;
        logic [7:0]  exp_b [$];
        logic [7:0]  got;
        int          waited;
        int          len;
        int          n_rd;
        int          i;
        n_rd = $fscanf(fd, "%h", tag);
        if (n_rd != 1)
            bad_line("R");
        exp_b.delete();
        exp_b.push_back(8'h04);
        exp_b.push_back(8'h01);
        exp_b.push_back(tag[15:8]);
        exp_b.push_back(tag[7:0]);
        for (i = 0; i < sec_bytes; i++)
            exp_b.push_back(sec_mem[i]);
        waited = 0;
        while (rx_runs.size() == 0 && waited < REPLY_TMO)
        begin
            @(posedge i_clk);
            waited++;
        end
        if (rx_runs.size() == 0)
        begin
            $display("timeout: no reply with tag %h within %0d cycles", tag, REPLY_TMO);
            other_errs++;
            abort = 1'b1;
        end
        else
        begin
            len = rx_runs.pop_front();
            checks++;
            if (len != exp_b.size())
            begin
                $display("ERR o_si_en run length: got %h, expected %h", len, exp_b.size());
                value_errs++;
            end
            for (i = 0; i < len; i++)
            begin
                got = rx_bytes.pop_front();
                if (i < exp_b.size())
                begin
                    checks++;
                    if (got !== exp_b[i])
                    begin
                        $display("ERR o_si byte %0d of reply %h: got %h, expected %h",
                                 i, tag, got, exp_b[i]);
                        value_errs++;
                    end
                end
            end
        end
    endtask

    // nothing may come out during a fixed wait
    task automatic check_quiet(input int cycles);
        repeat (cycles) @(posedge i_clk);
        checks++;
        if (rx_runs.size() != 0 || rx_bytes.size() != 0)
        begin
            $display("a reply of %0d bytes came out where none was expected",
                     rx_bytes.size());
            other_errs++;
            rx_runs.delete();
            rx_bytes.delete();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial
    begin
        int         ch;
        int         cycles;
        int         n_rd;
        logic [7:0] tag_ch;
        i_reset    = 1'b1;
        i_ts       = '0;
        i_ts_en    = 1'b0;
        i_con      = '0;
        i_con_en   = 1'b0;
        run_len    = 0;
        sec_bytes  = 0;
        checks     = 0;
        value_errs = 0;
        other_errs = 0;
        abort      = 1'b0;

        fd = $fopen("tb/si_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file tb/si_stimulus.txt");
            other_errs++;
            abort = 1'b1;
        end

        repeat (RESET_CYC) @(posedge i_clk);
        #DRIVE_DLY;
        i_reset = 1'b0;
        repeat (5) @(posedge i_clk);

        while (!abort)
        begin
            next_tag(ch);
            if (ch == -1)
                abort = 1'b1;  // end of file
            else
            begin
                tag_ch = 8'(ch);
                case (tag_ch)
                    "C": send_command();
                    "S": build_section();
                    "P": send_burst();
                    "R": check_reply();
                    "G", "N":
                    begin
                        n_rd = $fscanf(fd, "%h", cycles);
                        if (n_rd != 1)
                            bad_line("G or N");
                        else if (tag_ch == "G")
                            repeat (cycles) @(posedge i_clk);
                        else
                            check_quiet(cycles);
                    end
                    default:
                    begin
                        $display("stimulus file: unknown tag %c", tag_ch);
                        other_errs++;
                        abort = 1'b1;
                    end
                endcase
            end
        end
        if (fd != 0)
            $fclose(fd);
        if (other_errs == 0)
            check_quiet(END_QUIET);  // no stray reply at the end

        $display("checks %0d, errors %0d (wrong values %0d, other failures %0d)",
                 checks, value_errs + other_errs, value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
source/si_req_pkg.sv
source/ts_pkg.sv
source/si_cmd_parser.sv
source/ts_stream_filter.sv
source/ts_word_fifo.sv
source/si_section_capture.sv
source/si_section_ram.sv
source/si_reply_sender.sv
source/si_grabber_top.sv
tb/tb_si_grabber.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_si_grabber
FILELIST  = sources.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

//--- tb/si_stimulus.txt
# C: command bytes 0 to 16 | S: tid sec length_field seed | P: sfp ip port pid pusi cc alen ptr offset
# G: idle cycles | R: reply tag, the current section must follow | N: cycles with no reply (all hex)
# single packet, no adaptation field, pointer 0
C 5a 01 00 00 00 00 02 c0 a8 0a 05 04 d2 e0 11 42 01
G 8
S 42 01 025 3c
P 02 c0a80a05 04d2 0011 1 3 00 00 0
R 5a01
# adaptation field and nonzero pointer, same section
C 5a 02 00 00 00 00 02 c0 a8 0a 05 04 d2 e0 11 42 01
G 8
P 02 c0a80a05 04d2 0011 1 4 07 05 0
R 5a02
# 300 byte section over two packets
C 5a 03 00 00 00 00 02 c0 a8 0a 05 04 d2 e0 11 42 01
G 8
S 42 01 129 91
P 02 c0a80a05 04d2 0011 1 9 00 00 0
P 02 c0a80a05 04d2 0011 0 a 00 00 b7
R 5a03
# rejected by sfp, ip, port, pid, table id and section index, then a match
C 5a 04 00 00 00 00 02 c0 a8 0a 05 04 d2 e0 11 42 01
G 8
S 42 01 025 3c
P 03 c0a80a05 04d2 0011 1 1 00 00 0
N 12c
P 02 c0a80a06 04d2 0011 1 1 00 00 0
N 12c
P 02 c0a80a05 04d3 0011 1 1 00 00 0
N 12c
P 02 c0a80a05 04d2 0012 1 1 00 00 0
N 12c
S 4a 01 025 3c
P 02 c0a80a05 04d2 0011 1 1 00 00 0
N 12c
S 42 02 025 3c
P 02 c0a80a05 04d2 0011 1 1 00 00 0
N 12c
S 42 01 025 3c
P 02 c0a80a05 04d2 0011 1 2 00 00 0
R 5a04
# same burst again without a command, then a new command re-arms
P 02 c0a80a05 04d2 0011 1 2 00 00 0
N 12c
C 77 10 00 00 00 00 02 c0 a8 0a 05 04 d2 a0 11 42 01
G 8
P 02 c0a80a05 04d2 0011 1 2 00 00 0
R 7710
